// ==== logic/tcdm_bus_pkg.sv ====
// --------------------------------------------------------------------------
// TCDM bus field widths and request / response payload structs
// --------------------------------------------------------------------------

package tcdm_bus_pkg;

  parameter int unsigned tcdm_addr_w = 32;
  parameter int unsigned tcdm_data_w = 32;
  parameter int unsigned tcdm_be_w   = tcdm_data_w / 8;  // one strobe per byte

  // request beat, 69 bits
  typedef struct packed {
    logic [tcdm_addr_w-1:0] add;   // byte address
    logic                   wen;   // 1 = read, 0 = write
    logic [tcdm_be_w-1:0]   be;    // byte enables
    logic [tcdm_data_w-1:0] data;  // write data
  } tcdm_req_t;

  // response beat, read data only
  typedef struct packed {
    logic [tcdm_data_w-1:0] r_data;
  } tcdm_rsp_t;

endpackage

// ==== logic/fifo_pkg.sv ====
// --------------------------------------------------------------------------
// queue status flags and default queue depth
// --------------------------------------------------------------------------

package fifo_pkg;

  // depth used when the top level is not overridden
  parameter int unsigned default_depth = 8;

  typedef struct packed {
    logic empty;  // nothing stored
    logic full;   // no free slot
  } fifo_flags_t;

endpackage

// ==== logic/stream_fifo.sv ====
// --------------------------------------------------------------------------
// flip-flop FIFO with valid/ready ports and a type-parameterized payload
// --------------------------------------------------------------------------

module stream_fifo #(
  parameter int unsigned FIFO_DEPTH = fifo_pkg::default_depth,  // power of two, >= 2
  parameter type         payload_t  = logic
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,       // synchronous flush
  // push side
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  payload_t              push_data_i,
  // pop side
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output payload_t              pop_data_o,
  output fifo_pkg::fifo_flags_t flags_o
);

  localparam int unsigned ptr_w = $clog2(FIFO_DEPTH);
  localparam int unsigned cnt_w = ptr_w + 1;  // must reach FIFO_DEPTH itself

  payload_t         mem_q [FIFO_DEPTH];  // storage, no reset needed
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;             // occupancy
  logic             push_fire;
  logic             pop_fire;

  assign push_ready_o = (count_q != cnt_w'(FIFO_DEPTH));  // no slot freed by same-cycle pop
  assign pop_valid_o  = (count_q != '0);
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  assign pop_data_o = mem_q[rd_ptr_q];  // head, straight from the register

  assign flags_o.empty = ~pop_valid_o;
  assign flags_o.full  = ~push_ready_o;

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_fire)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or push and pop together
      endcase
    end
  end

  // written item shows up at the pop port one cycle later
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // occupancy stays within the storage over any sequence of pushes and pops
  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_w'(FIFO_DEPTH)
  );

  // a stalled head keeps its value until it is taken
  a_head_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pop_valid_o && !pop_ready_i && !clear_i) |=> $stable(pop_data_o)
  );

endmodule

// ==== logic/rsp_hold_buf.sv ====
// --------------------------------------------------------------------------
// one-entry catch register for memory responses ahead of the response FIFO
// --------------------------------------------------------------------------

module rsp_hold_buf (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    r_valid_i,     // memory response pulse, never stalled
  input  tcdm_bus_pkg::tcdm_rsp_t r_data_i,
  input  logic                    push_ready_i,  // response FIFO has room
  output logic                    push_valid_o,
  output tcdm_bus_pkg::tcdm_rsp_t push_data_o
);

  import tcdm_bus_pkg::*;

  logic      held_q;       // an entry is waiting for the FIFO
  tcdm_rsp_t held_data_q;
  logic      catch_en;     // response arrives and the FIFO refuses it

  assign catch_en = r_valid_i & ~push_ready_i;

  // a fresh response goes straight through, else offer the held one
  assign push_valid_o = r_valid_i | held_q;
  assign push_data_o  = r_valid_i ? r_data_i : held_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else if (clear_i) begin
      held_q <= 1'b0;
    end else begin
      held_q <= push_valid_o & ~push_ready_i;  // anything offered but not taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (catch_en) begin
      held_data_q <= r_data_i;
    end
  end

  // request gating upstream keeps a second response from landing on a full
  // buffer, otherwise the held entry would be overwritten
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(held_q && r_valid_i && !push_ready_i)
  );

endmodule

// ==== logic/tcdm_fifo_ctrl.sv ====
// --------------------------------------------------------------------------
// req/gnt mapping onto the queues, memory request gating, status flags
// --------------------------------------------------------------------------

module tcdm_fifo_ctrl (
  // target side handshake
  input  logic                  tgt_req_i,
  output logic                  tgt_gnt_o,
  // request queue
  output logic                  req_push_valid_o,
  input  logic                  req_push_ready_i,
  input  logic                  req_pop_valid_i,
  output logic                  req_pop_ready_o,
  input  fifo_pkg::fifo_flags_t req_flags_i,
  // response path
  input  logic                  rsp_push_ready_i,  // response FIFO can take a beat
  input  fifo_pkg::fifo_flags_t rsp_flags_i,
  // initiator side handshake
  output logic                  init_req_o,
  input  logic                  init_gnt_i,
  output logic                  init_r_ready_o,
  output fifo_pkg::fifo_flags_t flags_o
);

  // target req/gnt is the push handshake of the request queue
  assign req_push_valid_o = tgt_req_i;
  assign tgt_gnt_o        = req_push_ready_i;

  // only talk to memory while its answer has somewhere to go
  assign init_req_o      = req_pop_valid_i & rsp_push_ready_i;
  assign req_pop_ready_o = init_gnt_i;        // gnt only follows a raised req
  assign init_r_ready_o  = rsp_push_ready_i;  // advisory, responses are never refused

  // whole block is idle when both queues are drained
  assign flags_o.empty = req_flags_i.empty & rsp_flags_i.empty;
  assign flags_o.full  = 1'b0;  // not supported at this level

endmodule

// ==== logic/tcdm_fifo.sv ====
// --------------------------------------------------------------------------
// TCDM decoupling queue top: request FIFO, response FIFO, hold buffer, ctrl
// --------------------------------------------------------------------------

module tcdm_fifo #(
  parameter int unsigned FIFO_DEPTH = fifo_pkg::default_depth  // per queue
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  output fifo_pkg::fifo_flags_t   flags_o,             // only empty is valid
  // target side, towards the accelerator
  input  logic                    tgt_req_i,
  output logic                    tgt_gnt_o,
  input  tcdm_bus_pkg::tcdm_req_t tgt_req_payload_i,
  output logic                    tgt_r_valid_o,
  input  logic                    tgt_r_ready_i,
  output tcdm_bus_pkg::tcdm_rsp_t tgt_rsp_o,
  // initiator side, towards memory
  output logic                    init_req_o,
  input  logic                    init_gnt_i,
  output tcdm_bus_pkg::tcdm_req_t init_req_payload_o,
  input  logic                    init_r_valid_i,
  output logic                    init_r_ready_o,
  input  tcdm_bus_pkg::tcdm_rsp_t init_rsp_i
);

  import tcdm_bus_pkg::*;
  import fifo_pkg::*;

  logic        req_push_valid;
  logic        req_push_ready;
  logic        req_pop_valid;
  logic        req_pop_ready;
  fifo_flags_t req_flags;

  logic        rsp_push_valid;  // from the hold buffer
  logic        rsp_push_ready;
  tcdm_rsp_t   rsp_push_data;
  fifo_flags_t rsp_flags;

  tcdm_fifo_ctrl i_ctrl (
    .tgt_req_i        ( tgt_req_i      ),
    .tgt_gnt_o        ( tgt_gnt_o      ),
    .req_push_valid_o ( req_push_valid ),
    .req_push_ready_i ( req_push_ready ),
    .req_pop_valid_i  ( req_pop_valid  ),
    .req_pop_ready_o  ( req_pop_ready  ),
    .req_flags_i      ( req_flags      ),
    .rsp_push_ready_i ( rsp_push_ready ),
    .rsp_flags_i      ( rsp_flags      ),
    .init_req_o       ( init_req_o     ),
    .init_gnt_i       ( init_gnt_i     ),
    .init_r_ready_o   ( init_r_ready_o ),
    .flags_o          ( flags_o        )
  );

  // outgoing requests, target -> memory
  stream_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .payload_t  ( tcdm_req_t )
  ) i_req_fifo (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .clear_i      ( clear_i            ),
    .push_valid_i ( req_push_valid     ),
    .push_ready_o ( req_push_ready     ),
    .push_data_i  ( tgt_req_payload_i  ),
    .pop_valid_o  ( req_pop_valid      ),
    .pop_ready_i  ( req_pop_ready      ),
    .pop_data_o   ( init_req_payload_o ),
    .flags_o      ( req_flags          )
  );

  // catches a response the queue cannot take in its arrival cycle
  rsp_hold_buf i_hold_buf (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .r_valid_i    ( init_r_valid_i ),
    .r_data_i     ( init_rsp_i     ),
    .push_ready_i ( rsp_push_ready ),
    .push_valid_o ( rsp_push_valid ),
    .push_data_o  ( rsp_push_data  )
  );

  // incoming responses, memory -> target
  stream_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .payload_t  ( tcdm_rsp_t )
  ) i_rsp_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( rsp_push_valid ),
    .push_ready_o ( rsp_push_ready ),
    .push_data_i  ( rsp_push_data  ),
    .pop_valid_o  ( tgt_r_valid_o  ),
    .pop_ready_i  ( tgt_r_ready_i  ),
    .pop_data_o   ( tgt_rsp_o      ),
    .flags_o      ( rsp_flags      )
  );

endmodule

// ==== tb/tcdm_fifo_checker.sv ====
// --------------------------------------------------------------------------
// target-side monitor: response prediction, in-order compare, error counts
// --------------------------------------------------------------------------

module tcdm_fifo_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    tgt_req_i,
  input  logic                    tgt_gnt_i,
  input  tcdm_bus_pkg::tcdm_req_t tgt_req_payload_i,
  input  logic                    tgt_r_valid_i,
  input  logic                    tgt_r_ready_i,
  input  tcdm_bus_pkg::tcdm_rsp_t tgt_rsp_i
);

  import tcdm_bus_pkg::*;

  logic [tcdm_data_w-1:0] mem_model [logic [tcdm_addr_w-1:0]];  // write-through copy
  logic                   exp_is_rd [$];  // one entry per accepted request
  logic [tcdm_data_w-1:0] exp_data [$];
  string                  test_name = "none";
  int                     checks = 0;
  int                     errors = 0;
  int                     pending_cnt = 0;  // requests still waiting for a response

  task automatic compare(input string what, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  always @(posedge clk_i or negedge rst_ni) begin : track
    logic                   rd;
    logic [tcdm_data_w-1:0] d;
    if (!rst_ni) begin
      exp_is_rd.delete();
      exp_data.delete();
    end else if (clear_i) begin
      exp_is_rd.delete();  // queued requests are dropped by the flush
      exp_data.delete();
    end else begin
      // response side first, a request taken now cannot answer in this cycle
      if (tgt_r_valid_i && tgt_r_ready_i) begin
        if (exp_is_rd.size() == 0) begin
          report("response arrived with no request outstanding");
        end else begin
          rd = exp_is_rd.pop_front();
          d  = exp_data.pop_front();
          if (rd) compare("read data", d, tgt_rsp_i.r_data);  // write data is don't care
        end
      end
      if (tgt_req_i && tgt_gnt_i) begin
        if (!tgt_req_payload_i.wen) begin
          mem_model[tgt_req_payload_i.add] = tgt_req_payload_i.data;
          exp_is_rd.push_back(1'b0);
          exp_data.push_back('0);
        end else begin
          exp_is_rd.push_back(1'b1);
          exp_data.push_back(mem_model.exists(tgt_req_payload_i.add) ?
                             mem_model[tgt_req_payload_i.add] : '0);  // unwritten reads 0
        end
      end
    end
    pending_cnt = exp_is_rd.size();
  end

endmodule

// ==== tb/tb_tcdm_fifo.sv ====
// --------------------------------------------------------------------------
// testbench top: clock, reset, file-driven stimulus, memory responder model
// --------------------------------------------------------------------------

module tb_tcdm_fifo;

  import tcdm_bus_pkg::*;
  import fifo_pkg::*;

  localparam int unsigned depth   = 4;
  localparam int          timeout = 300;  // cycles allowed per wait loop

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  logic        clear_i = 1'b0;
  fifo_flags_t flags_o;
  logic        tgt_req_i = 1'b0;
  logic        tgt_gnt_o;
  tcdm_req_t   tgt_req_payload_i = '0;
  logic        tgt_r_valid_o;
  logic        tgt_r_ready_i = 1'b1;
  tcdm_rsp_t   tgt_rsp_o;
  logic        init_req_o;
  logic        init_gnt_i = 1'b0;
  tcdm_req_t   init_req_payload_o;
  logic        init_r_valid_i = 1'b0;
  logic        init_r_ready_o;
  tcdm_rsp_t   init_rsp_i = '0;

  logic [31:0] mem [logic [31:0]];  // memory behind the initiator port
  logic        rsp_pend = 1'b0;     // granted last cycle, answer now
  logic [31:0] rsp_val = '0;
  logic        gnt_next = 1'b0;
  logic        rdy_next = 1'b1;
  int          cyc = 0;
  int          gnt_pct = 0;         // percent of cycles gnt is withheld
  logic        gnt_hold = 1'b0;     // gnt stays low until the request FIFO is full
  int          rdy_until = 0;       // tgt_r_ready low before this cycle
  int          drop_cnt = 0;        // cycles with init_r_ready low
  int          bad_empty_cnt = 0;
  int          gate_bad_cnt = 0;
  int          tests_run = 0;
  string       t_name [$];
  string       t_op [$];
  logic [31:0] t_addr [$];
  logic [31:0] t_data [$];
  int          t_gnt [$];
  int          t_rdy [$];

  always #4 clk_i = ~clk_i;

  tcdm_fifo #(.FIFO_DEPTH(depth)) uut (.*);

  tcdm_fifo_checker u_checker (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .clear_i           ( clear_i           ),
    .tgt_req_i         ( tgt_req_i         ),
    .tgt_gnt_i         ( tgt_gnt_o         ),
    .tgt_req_payload_i ( tgt_req_payload_i ),
    .tgt_r_valid_i     ( tgt_r_valid_o     ),
    .tgt_r_ready_i     ( tgt_r_ready_i     ),
    .tgt_rsp_i         ( tgt_rsp_o         )
  );

  // memory side takes granted requests and picks the next gnt and ready levels
  always @(posedge clk_i) begin
    cyc      <= cyc + 1;
    rsp_pend <= rst_ni & init_req_o & init_gnt_i;
    if (init_req_o && init_gnt_i) begin
      if (init_req_payload_o.wen) begin
        rsp_val <= mem.exists(init_req_payload_o.add) ? mem[init_req_payload_o.add] : '0;
      end else begin
        mem[init_req_payload_o.add] = init_req_payload_o.data;
        rsp_val <= '0;  // write answers carry no data
      end
    end
    gnt_next <= !gnt_hold && ($urandom_range(99) >= gnt_pct);
    rdy_next <= (cyc + 1 >= rdy_until);
    if (rst_ni && !init_r_ready_o) begin
      drop_cnt <= drop_cnt + 1;
      if (flags_o.empty) bad_empty_cnt <= bad_empty_cnt + 1;  // response FIFO is full here
    end
    if (init_req_o && !init_r_ready_o) gate_bad_cnt <= gate_bad_cnt + 1;
  end

  // DUT inputs change on the falling edge only
  always @(negedge clk_i) begin
    init_r_valid_i    <= rsp_pend;
    init_rsp_i.r_data <= rsp_val;
    init_gnt_i        <= init_req_o & gnt_next;  // gnt only with a raised req
    tgt_r_ready_i     <= rdy_next;
  end

  task automatic send_req(input int i);
    int to;
    to = 0;
    tgt_req_i              = 1'b1;
    tgt_req_payload_i.add  = t_addr[i];
    tgt_req_payload_i.wen  = (t_op[i] == "R");
    tgt_req_payload_i.be   = '1;
    tgt_req_payload_i.data = t_data[i];
    while (!tgt_gnt_o && to <= timeout) begin
      @(negedge clk_i);
      to++;
    end
    if (!tgt_gnt_o) u_checker.report("timeout: request was never granted");
    @(negedge clk_i);  // taken on the rising edge just passed
    tgt_req_i = 1'b0;
  endtask

  // requests sit in the queue with gnt held, then get flushed
  task automatic apply_clear();
    int i;
    u_checker.compare("empty before clear", 0, flags_o.empty);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i  = 1'b0;
    gnt_hold = 1'b0;
    for (i = 0; i < 10; i++) begin
      u_checker.compare("empty after clear", 1, flags_o.empty);
      u_checker.compare("r_valid after clear", 0, tgt_r_valid_o);
      @(negedge clk_i);
    end
  endtask

  task automatic run_test(input int first, input int last);
    int   i;
    int   to;
    int   granted;
    int   err0;
    int   drop0;
    int   bad0;
    int   gate0;
    logic full_seen;
    u_checker.test_name = t_name[first];
    err0      = u_checker.errors;
    drop0     = drop_cnt;
    bad0      = bad_empty_cnt;
    gate0     = gate_bad_cnt;
    granted   = 0;
    full_seen = 1'b0;
    gnt_hold  = (t_gnt[first] >= 100);
    gnt_pct   = gnt_hold ? 0 : t_gnt[first];
    rdy_until = cyc + t_rdy[first];
    for (i = first; i <= last; i++) begin
      if (t_op[i] == "C") begin
        apply_clear();
      end else begin
        if (gnt_hold && !tgt_gnt_o) begin  // request FIFO just filled up
          u_checker.compare("grants before full", depth, granted);
          u_checker.compare("empty while full", 0, flags_o.empty);
          full_seen = 1'b1;
          gnt_hold  = 1'b0;
        end
        send_req(i);
        granted++;
        // the request pushed at the last edge cannot have left yet
        u_checker.compare("empty with request stored", 0, flags_o.empty);
      end
    end
    if (t_gnt[first] >= 100 && granted > depth) begin
      u_checker.compare("request FIFO filled", 1, full_seen);
    end
    gnt_hold = 1'b0;
    to = 0;
    while (u_checker.pending_cnt != 0 && to <= timeout) begin
      @(negedge clk_i);
      to++;
    end
    if (u_checker.pending_cnt != 0) u_checker.report("timeout: responses did not drain");
    u_checker.compare("empty after drain", 1, flags_o.empty);
    if (t_rdy[first] > 0) u_checker.compare("init_r_ready dropped", 1, drop_cnt > drop0);
    u_checker.compare("empty high while blocked", 0, bad_empty_cnt - bad0);
    u_checker.compare("init_req while blocked", 0, gate_bad_cnt - gate0);
    tests_run++;
    $display("test %s: %s", t_name[first], (u_checker.errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    int          fd;
    int          n;
    int          first;
    int          i;
    int          g;
    int          r;
    string       line;
    string       nm;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    void'($urandom(32'hf285));
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    u_checker.test_name = "reset";
    u_checker.compare("tgt_gnt", 1, tgt_gnt_o);
    u_checker.compare("tgt_r_valid", 0, tgt_r_valid_o);
    u_checker.compare("init_req", 0, init_req_o);
    u_checker.compare("empty", 1, flags_o.empty);
    u_checker.compare("full", 0, flags_o.full);  // unsupported, tied low
    tests_run++;
    $display("test reset: %s", (u_checker.errors == 0) ? "ok" : "failed");
    u_checker.test_name = "setup";
    fd = $fopen("tb/tcdm_fifo_testdata.txt", "r");
    if (fd == 0) begin
      u_checker.report("could not open tb/tcdm_fifo_testdata.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %s %h %h %d %d", nm, op, a, d, g, r);
          if (n == 6) begin
            t_name.push_back(nm);
            t_op.push_back(op);
            t_addr.push_back(a);
            t_data.push_back(d);
            t_gnt.push_back(g);
            t_rdy.push_back(r);
          end
        end
      end
      $fclose(fd);
    end
    if (t_name.size() == 0) u_checker.report("test data file holds no transactions");
    first = 0;
    for (i = 1; i <= t_name.size(); i++) begin  // consecutive lines with one name form a test
      if (i == t_name.size() || t_name[i] != t_name[first]) begin
        run_test(first, i - 1);
        first = i;
      end
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, u_checker.checks,
             u_checker.errors);
    if (u_checker.errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/tcdm_fifo_testdata.txt ====
# test  op(W write, R read, C clear)  addr  wdata  gnt_stall_pct  rready_stall_cycles
# stall columns come from a test's first line, gnt_stall_pct 100 holds gnt until FIFO full
wr_rd_back       W 00000000 a5a50001 0 0
wr_rd_back       W 00000004 5a5a0002 0 0
wr_rd_back       W 00000008 deadbeef 0 0
wr_rd_back       W 0000000c 0badf00d 0 0
wr_rd_back       R 00000000 00000000 0 0
wr_rd_back       R 00000004 00000000 0 0
wr_rd_back       R 00000008 00000000 0 0
wr_rd_back       R 0000000c 00000000 0 0
mem_stall        W 00000100 10203040 40 0
mem_stall        W 00000104 50607080 40 0
mem_stall        R 00000100 00000000 40 0
mem_stall        W 00000108 90a0b0c0 40 0
mem_stall        R 00000104 00000000 40 0
mem_stall        R 00000108 00000000 40 0
mem_stall        R 00000000 00000000 40 0
mem_stall        W 00000100 ffff0000 40 0
mem_stall        R 00000100 00000000 40 0
queue_full       W 00000200 11110000 100 0
queue_full       W 00000204 22220000 100 0
queue_full       W 00000208 33330000 100 0
queue_full       R 00000200 00000000 100 0
queue_full       R 00000204 00000000 100 0
queue_full       R 00000208 00000000 100 0
rsp_backpressure R 00000000 00000000 0 40
rsp_backpressure R 00000004 00000000 0 40
rsp_backpressure R 00000008 00000000 0 40
rsp_backpressure R 0000000c 00000000 0 40
rsp_backpressure R 00000100 00000000 0 40
rsp_backpressure R 00000104 00000000 0 40
rsp_backpressure R 00000108 00000000 0 40
rsp_backpressure R 00000200 00000000 0 40
rsp_backpressure R 00000204 00000000 0 40
rsp_backpressure R 00000208 00000000 0 40
clear_flush      R 00000000 00000000 100 0
clear_flush      R 00000004 00000000 100 0
clear_flush      R 00000008 00000000 100 0
clear_flush      C 00000000 00000000 100 0
empty_flag       W 00000300 cafe0001 0 0
empty_flag       R 00000300 00000000 0 0

// ==== tcdm_fifo.f ====
logic/tcdm_bus_pkg.sv
logic/fifo_pkg.sv
logic/stream_fifo.sv
logic/rsp_hold_buf.sv
logic/tcdm_fifo_ctrl.sv
logic/tcdm_fifo.sv
tb/tcdm_fifo_checker.sv
tb/tb_tcdm_fifo.sv
